/* src.f */
+incdir+design
design/cam_pkg.sv
design/sync_fifo.sv
design/cmos_capture.sv
design/frame_writer.sv
design/frame_reader.sv
design/frame_store.sv
design/video_timing.sv
design/cam_display_top.sv
verif/cam_display_assert.sv
verif/tb_checker.sv
verif/tb_top.sv

/* Makefile */
SIM := obj_dir/Vtb_top
SRCS := $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qF '*** PASSED ***'

$(SIM): $(SRCS) src.f
	verilator --binary --timing --assert -f src.f --top-module tb_top -o Vtb_top

clean:
	rm -rf obj_dir

/* verif/tb_top.sv */
`default_nettype none

`include "cam_settings.svh"

module tb_top;

    import cam_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       cam_vsync;
    logic       cam_href;
    logic [7:0] cam_data;
    logic       cam_rst_n;
    logic       vid_hs;
    logic       vid_vs;
    logic       vid_de;
    rgb_t       vid_r;
    rgb_t       vid_g;
    rgb_t       vid_b;

    logic   check_en;
    pixel_t sensor_img [`FRAME_PIXELS];   // what the sensor sends
    pixel_t exp_img [`FRAME_PIXELS];      // what the display should show
    int     err_count;
    int     check_count;
    int     frame_count;
    int     frames_checked;
    int     timeouts;

    cam_display_top cam_display_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_data  (cam_data),
        .cam_rst_n (cam_rst_n),
        .vid_hs    (vid_hs),
        .vid_vs    (vid_vs),
        .vid_de    (vid_de),
        .vid_r     (vid_r),
        .vid_g     (vid_g),
        .vid_b     (vid_b)
    );

    tb_checker tb_checker_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .cam_rst_n      (cam_rst_n),
        .vid_hs         (vid_hs),
        .vid_vs         (vid_vs),
        .vid_de         (vid_de),
        .vid_r          (vid_r),
        .vid_g          (vid_g),
        .vid_b          (vid_b),
        .check_en       (check_en),
        .exp_img        (exp_img),
        .err_count      (err_count),
        .check_count    (check_count),
        .frame_count    (frame_count),
        .frames_checked (frames_checked)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s: %s", name,
                 (err_count + timeouts == fails_before) ? "ok" : "errors");
    endtask

    // vsync pulse, then one href burst of byte pairs per line
    task automatic send_frame;
        int x;
        int y;
        @(posedge clk) cam_vsync <= 1'b1;
        repeat (3) @(posedge clk);
        cam_vsync <= 1'b0;
        repeat (6) @(posedge clk);
        for (y = 0; y < `V_ACTIVE; y++)
        begin
            for (x = 0; x < `H_ACTIVE; x++)
            begin
                @(posedge clk);
                cam_href <= 1'b1;
                cam_data <= sensor_img[y * `H_ACTIVE + x][15:8];  // high byte first
                @(posedge clk);
                cam_data <= sensor_img[y * `H_ACTIVE + x][7:0];
            end
            @(posedge clk) cam_href <= 1'b0;
            repeat (8) @(posedge clk);
        end
    endtask

    task automatic wait_release;
        int n;
        for (n = 0; n < 200 && !cam_rst_n; n++)
            @(posedge clk);
        if (!cam_rst_n)
            note_timeout("sensor reset release");
    endtask

    task automatic wait_checked(input int target);
        int n;
        for (n = 0; n < 2000 && frames_checked < target; n++)
            @(posedge clk);
        if (frames_checked < target)
            note_timeout("checked display frames");
    endtask

    // two full sensor frames, then keep sending until two display frames are checked
    task automatic show_image;
        int n;
        int target;
        send_frame();
        send_frame();
        check_en <= 1'b1;
        target = frames_checked + 2;
        for (n = 0; n < 12 && frames_checked < target; n++)
            send_frame();
        if (frames_checked < target)
            note_timeout("checked display frames");
        check_en <= 1'b0;
        wait_checked(target + 1);   // frame in progress still compares
    endtask

    initial
    begin
        int i;
        int n;
        int e0;
        void'($urandom(17));
        rst_n     = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = '0;
        check_en  = 1'b0;
        timeouts  = 0;
        for (i = 0; i < `FRAME_PIXELS; i++)
        begin
            sensor_img[i] = '0;
            exp_img[i]    = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        e0 = err_count + timeouts;
        wait_release();
        report_test("reset and sensor release", e0);

        e0 = err_count + timeouts;
        n = frame_count + 3;
        for (i = 0; i < 2000 && frame_count < n; i++)
            @(posedge clk);
        if (frame_count < n)
            note_timeout("display frames");
        report_test("display geometry", e0);

        // ==================== gradient image
        e0 = err_count + timeouts;
        for (i = 0; i < `FRAME_PIXELS; i++)
        begin
            sensor_img[i] = {5'(i * 3), 6'(i * 2 + 1), 5'(31 - i)};
            exp_img[i]    = sensor_img[i];
        end
        show_image();
        report_test("gradient image", e0);

        // ==================== random image
        e0 = err_count + timeouts;
        for (i = 0; i < `FRAME_PIXELS; i++)
        begin
            sensor_img[i] = 16'($urandom);
            exp_img[i]    = sensor_img[i];
        end
        show_image();
        report_test("random image", e0);

        // ==================== image sent during sensor reset
        e0 = err_count + timeouts;
        for (i = 0; i < `FRAME_PIXELS; i++)
            sensor_img[i] = ~exp_img[i];
        @(posedge clk) rst_n <= 1'b0;
        fork
            send_frame();
            begin
                repeat (80) @(posedge clk);
                rst_n <= 1'b1;      // last line arrives before cam_rst_n rises
            end
        join
        wait_release();
        check_en <= 1'b1;
        n = frames_checked + 2;
        wait_checked(n);
        check_en <= 1'b0;
        report_test("bytes ignored before release", e0);

        @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeouts);
        if (err_count == 0 && timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_checker.sv */
`default_nettype none

`include "cam_settings.svh"

module tb_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cam_rst_n,
    input  logic            vid_hs,
    input  logic            vid_vs,
    input  logic            vid_de,
    input  cam_pkg::rgb_t   vid_r,
    input  cam_pkg::rgb_t   vid_g,
    input  cam_pkg::rgb_t   vid_b,
    input  logic            check_en,
    input  cam_pkg::pixel_t exp_img [`FRAME_PIXELS],
    output int              err_count,
    output int              check_count,
    output int              frame_count,
    output int              frames_checked
);

    import cam_pkg::*;

    localparam int HT = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int VT = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;

    int   errs = 0;
    int   checks = 0;
    int   frames = 0;
    int   done_frames = 0;
    int   rel_cnt = 0;
    int   run = 0;
    int   lines = 0;
    int   de_samples = 0;
    int   vs_len = 0;
    int   hs_len = 0;
    int   hs_pulses = 0;
    logic rel_seen = 1'b0;
    logic seen_vs = 1'b0;
    logic checking = 1'b0;
    logic vs_q = 1'b0;
    logic hs_q = 1'b0;
    logic de_q = 1'b0;

    // RGB565 to RGB888, low bits zero
    function automatic logic [23:0] expand(input pixel_t p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    task automatic wrong_value(input string what, input int exp_v, input int got_v);
        errs++;
        $display("mismatch at %0t: %s expected %0h got %0h", $time, what, exp_v, got_v);
    endtask

    // outputs hold for two clk per pixel, so every count is in samples
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            checks++;
            if (vid_hs || vid_vs || vid_de || cam_rst_n ||
                (vid_r != '0) || (vid_g != '0) || (vid_b != '0))
            begin
                errs++;
                $display("outputs were not low during reset at %0t", $time);
            end
            rel_cnt   = 0;
            rel_seen  = 1'b0;
            seen_vs   = 1'b0;
            checking  = 1'b0;
            vs_q      = 1'b0;
            hs_q      = 1'b0;
            de_q      = 1'b0;
            run       = 0;
            vs_len    = 0;
            hs_len    = 0;
            hs_pulses = 0;
        end
        else
        begin
            if (!rel_seen)
            begin
                if (cam_rst_n)
                begin
                    rel_seen = 1'b1;
                    checks++;
                    if (rel_cnt != `SENSOR_RST_CYCLES)
                        wrong_value("sensor release cycles", `SENSOR_RST_CYCLES, rel_cnt);
                end
                else
                    rel_cnt++;
            end
            if (vid_vs && !vs_q)
            begin
                if (seen_vs)
                begin
                    checks += 3;
                    if (lines != `V_ACTIVE)
                        wrong_value("lines per frame", `V_ACTIVE, lines);
                    if (de_samples != 2 * `FRAME_PIXELS)
                        wrong_value("pixels per frame", `FRAME_PIXELS, de_samples / 2);
                    if (hs_pulses != VT)
                        wrong_value("hsync pulses per frame", VT, hs_pulses);
                    if (checking)
                        done_frames++;
                end
                frames++;
                seen_vs    = 1'b1;
                checking   = check_en;
                lines      = 0;
                de_samples = 0;
                hs_pulses  = 0;
            end
            if (vid_vs)
                vs_len++;
            else if (vs_q)
            begin
                checks++;
                if (vs_len != 2 * HT * `V_SYNC)
                    wrong_value("vsync length", 2 * HT * `V_SYNC, vs_len);
                vs_len = 0;
            end
            if (vid_hs && !hs_q)
                hs_pulses++;
            if (vid_hs)
                hs_len++;
            else if (hs_q)
            begin
                checks++;
                if (hs_len != 2 * `H_SYNC)
                    wrong_value("hsync length", 2 * `H_SYNC, hs_len);
                hs_len = 0;
            end
            if (vid_de)
            begin
                if (checking && de_samples < 2 * `FRAME_PIXELS)
                begin
                    checks++;
                    if ({vid_r, vid_g, vid_b} != expand(exp_img[de_samples / 2]))
                        wrong_value("pixel", expand(exp_img[de_samples / 2]),
                                    {vid_r, vid_g, vid_b});
                end
                de_samples++;
                run++;
            end
            else if (de_q)
            begin
                checks++;
                if (run != 2 * `H_ACTIVE)
                    wrong_value("pixels per line", `H_ACTIVE, run / 2);
                lines++;
                run = 0;
            end
            vs_q = vid_vs;
            hs_q = vid_hs;
            de_q = vid_de;
        end
        err_count      <= errs;
        check_count    <= checks;
        frame_count    <= frames;
        frames_checked <= done_frames;
    end

endmodule

`default_nettype wire

/* verif/cam_display_assert.sv */
`default_nettype none

module cam_display_assert (
    input logic clk,
    input logic rst_n,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty,
    input logic wr_ack,
    input logic rd_ack
);

    push_not_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("push into a full FIFO");

    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("pop from an empty FIFO");

    one_ack: assert property (@(posedge clk) disable iff (!rst_n) !(wr_ack && rd_ack))
        else $error("two acks in one cycle");

endmodule

bind sync_fifo cam_display_assert fifo_assert_inst (
    .clk (clk), .rst_n (rst_n), .push (push), .pop (pop), .full (full),
    .empty (empty), .wr_ack (1'b0), .rd_ack (1'b0)
);

bind frame_store cam_display_assert store_assert_inst (
    .clk (clk), .rst_n (rst_n), .push (1'b0), .pop (1'b0), .full (1'b0),
    .empty (1'b0), .wr_ack (wr_ack), .rd_ack (rd_ack)
);

`default_nettype wire

/* design/cam_display_top.sv */
`default_nettype none

module cam_display_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cam_vsync,
    input  logic          cam_href,
    input  logic [7:0]    cam_data,
    output logic          cam_rst_n,
    output logic          vid_hs,
    output logic          vid_vs,
    output logic          vid_de,
    output cam_pkg::rgb_t vid_r,
    output cam_pkg::rgb_t vid_g,
    output cam_pkg::rgb_t vid_b
);

    import cam_pkg::*;

    // ====================
    // camera path
    // ====================
    logic   pix_valid;
    pixel_t pix_data;
    logic   cam_frame_start;
    logic   wr_req;
    logic   wr_ack;
    addr_t  wr_addr;
    pixel_t wr_pixel;

    // ====================
    // display path
    // ====================
    logic   pix_tick;
    logic   hs;
    logic   vs;
    logic   de;
    logic   frame_start;
    logic   rd_req;
    logic   rd_ack;
    logic   rd_valid;
    addr_t  rd_addr;
    pixel_t rd_pixel;

    cmos_capture cmos_capture_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .cam_vsync       (cam_vsync),
        .cam_href        (cam_href),
        .cam_data        (cam_data),
        .cam_rst_n       (cam_rst_n),
        .pix_valid       (pix_valid),
        .pix_data        (pix_data),
        .cam_frame_start (cam_frame_start)
    );

    frame_writer frame_writer_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .pix_valid       (pix_valid),
        .pix_data        (pix_data),
        .cam_frame_start (cam_frame_start),
        .wr_req          (wr_req),
        .wr_addr         (wr_addr),
        .wr_pixel        (wr_pixel),
        .wr_ack          (wr_ack)
    );

    frame_store frame_store_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .wr_ack   (wr_ack),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_ack   (rd_ack),
        .rd_valid (rd_valid),
        .rd_pixel (rd_pixel)
    );

    video_timing video_timing_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_tick    (pix_tick),
        .hs          (hs),
        .vs          (vs),
        .de          (de),
        .frame_start (frame_start)
    );

    frame_reader frame_reader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .pix_tick    (pix_tick),
        .de          (de),
        .hs          (hs),
        .vs          (vs),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_ack      (rd_ack),
        .rd_valid    (rd_valid),
        .rd_pixel    (rd_pixel),
        .vid_hs      (vid_hs),
        .vid_vs      (vid_vs),
        .vid_de      (vid_de),
        .vid_r       (vid_r),
        .vid_g       (vid_g),
        .vid_b       (vid_b)
    );

endmodule

`default_nettype wire

/* design/video_timing.sv */
`default_nettype none

`include "cam_settings.svh"

module video_timing (
    input  logic clk,
    input  logic rst_n,
    output logic pix_tick,
    output logic hs,
    output logic vs,
    output logic de,
    output logic frame_start
);

    localparam int HT = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int VT = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int HW = $clog2(HT);
    localparam int VW = $clog2(VT);

    localparam logic [HW-1:0] H_ACT  = HW'(`H_ACTIVE);
    localparam logic [HW-1:0] HS_BEG = HW'(`H_ACTIVE + `H_FP);
    localparam logic [HW-1:0] HS_END = HW'(`H_ACTIVE + `H_FP + `H_SYNC);
    localparam logic [HW-1:0] H_LAST = HW'(HT - 1);
    localparam logic [VW-1:0] V_ACT  = VW'(`V_ACTIVE);
    localparam logic [VW-1:0] VS_BEG = VW'(`V_ACTIVE + `V_FP);
    localparam logic [VW-1:0] VS_END = VW'(`V_ACTIVE + `V_FP + `V_SYNC);
    localparam logic [VW-1:0] V_LAST = VW'(VT - 1);

    logic          div_q;
    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;

    // raster starts at the vsync line, so the first tick opens a frame
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_q <= 1'b0;
            h_cnt <= '0;
            v_cnt <= VS_BEG;
        end
        else
        begin
            div_q <= ~div_q;                // pixel every second clk
            if (div_q)
            begin
                if (h_cnt == H_LAST)
                begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
                end
                else
                    h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign pix_tick    = div_q;
    assign hs          = (h_cnt >= HS_BEG) && (h_cnt < HS_END);  // active high
    assign vs          = (v_cnt >= VS_BEG) && (v_cnt < VS_END);
    assign de          = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign frame_start = pix_tick && (h_cnt == '0) && (v_cnt == VS_BEG);

endmodule

`default_nettype wire

/* design/frame_store.sv */
`default_nettype none

`include "cam_settings.svh"

module frame_store (
    input  logic            clk,
    input  logic            rst_n,
    // camera side
    input  logic            wr_req,
    input  cam_pkg::addr_t  wr_addr,
    input  cam_pkg::pixel_t wr_pixel,
    output logic            wr_ack,
    // display side
    input  logic            rd_req,
    input  cam_pkg::addr_t  rd_addr,
    output logic            rd_ack,
    output logic            rd_valid,
    output cam_pkg::pixel_t rd_pixel
);

    import cam_pkg::*;

    pixel_t    ram [`FRAME_PIXELS];
    port_sel_t sel;
    addr_t     ram_addr;

    // ====================
    // fixed priority, display first
    // ====================
    assign sel      = rd_req ? PORT_RD : PORT_WR;
    assign rd_ack   = (sel == PORT_RD);
    assign wr_ack   = (sel == PORT_WR) & wr_req;
    assign ram_addr = (sel == PORT_RD) ? rd_addr : wr_addr;  // single port

    // ====================
    // frame RAM
    // ====================
    always_ff @(posedge clk)
    begin
        if (wr_ack)
            ram[ram_addr] <= wr_pixel;
        if (rd_ack)
            rd_pixel <= ram[ram_addr];  // one cycle latency
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_ack;
    end

endmodule

`default_nettype wire

/* design/frame_reader.sv */
`default_nettype none

`include "cam_settings.svh"

module frame_reader (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            frame_start,
    input  logic            pix_tick,
    input  logic            de,
    input  logic            hs,
    input  logic            vs,
    output logic            rd_req,
    output cam_pkg::addr_t  rd_addr,
    input  logic            rd_ack,
    input  logic            rd_valid,
    input  cam_pkg::pixel_t rd_pixel,
    output logic            vid_hs,
    output logic            vid_vs,
    output logic            vid_de,
    output cam_pkg::rgb_t   vid_r,
    output cam_pkg::rgb_t   vid_g,
    output cam_pkg::rgb_t   vid_b
);

    import cam_pkg::*;

    localparam int LVL_W = $clog2(`FIFO_DEPTH + 1);
    localparam logic [LVL_W-1:0] LVL_MAX   = LVL_W'(`FIFO_DEPTH);
    localparam addr_t            ADDR_LAST = addr_t'(`FRAME_PIXELS - 1);

    logic             armed;      // set by the first display frame start
    logic [LVL_W-1:0] level;      // FIFO entries plus reads in flight
    logic             pop;
    logic             pop_ok;
    logic             fifo_empty;
    pixel_t           head;

    assign pop    = pix_tick & de;
    assign pop_ok = pop & ~fifo_empty;
    // no new read in the flush cycle, so nothing stale lands afterwards
    assign rd_req = armed & ~frame_start & (level != LVL_MAX);

    // ====================
    // prefetch
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            armed   <= 1'b0;
            level   <= '0;
            rd_addr <= '0;
        end
        else if (frame_start)
        begin
            armed   <= 1'b1;
            level   <= '0;
            rd_addr <= '0;
        end
        else
        begin
            if (rd_ack)
                rd_addr <= (rd_addr == ADDR_LAST) ? '0 : rd_addr + 1'b1;
            case ({rd_ack, pop_ok})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    sync_fifo #(
        .T (pixel_t)
    ) rd_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rd_valid),
        .din   (rd_pixel),
        .pop   (pop),
        .flush (frame_start),   // drops the tail of the previous frame
        .dout  (head),
        .full  (),
        .empty (fifo_empty)
    );

    // ====================
    // output stage
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vid_hs <= 1'b0;
            vid_vs <= 1'b0;
            vid_de <= 1'b0;
            vid_r  <= '0;
            vid_g  <= '0;
            vid_b  <= '0;
        end
        else if (pix_tick)
        begin
            vid_hs <= hs;
            vid_vs <= vs;
            vid_de <= de;
            vid_r  <= de ? {head[15:11], 3'b000} : '0;  // low bits zero-filled
            vid_g  <= de ? {head[10:5], 2'b00} : '0;
            vid_b  <= de ? {head[4:0], 3'b000} : '0;
        end
    end

endmodule

`default_nettype wire

/* design/frame_writer.sv */
`default_nettype none

`include "cam_settings.svh"

module frame_writer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pix_valid,
    input  cam_pkg::pixel_t pix_data,
    input  logic            cam_frame_start,
    output logic            wr_req,
    output cam_pkg::addr_t  wr_addr,
    output cam_pkg::pixel_t wr_pixel,
    input  logic            wr_ack
);

    import cam_pkg::*;

    localparam addr_t ADDR_LAST = addr_t'(`FRAME_PIXELS - 1);

    addr_t     next_addr;
    wr_entry_t entry_in;
    wr_entry_t entry_head;
    logic      fifo_empty;

    assign entry_in = '{addr: next_addr, pixel: pix_data};

    // address advances even for a dropped pixel, so later ones stay in place
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            next_addr <= '0;
        else if (cam_frame_start)
            next_addr <= '0;
        else if (pix_valid)
            next_addr <= (next_addr == ADDR_LAST) ? '0 : next_addr + 1'b1;
    end

    sync_fifo #(
        .T (wr_entry_t)
    ) wr_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (pix_valid),
        .din   (entry_in),
        .pop   (wr_ack),        // head leaves once the store takes it
        .flush (1'b0),
        .dout  (entry_head),
        .full  (),
        .empty (fifo_empty)
    );

    assign wr_req   = ~fifo_empty;  // head is held until acked
    assign wr_addr  = entry_head.addr;
    assign wr_pixel = entry_head.pixel;

endmodule

`default_nettype wire

/* design/cmos_capture.sv */
`default_nettype none

`include "cam_settings.svh"

module cmos_capture (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cam_vsync,
    input  logic            cam_href,
    input  logic [7:0]      cam_data,
    output logic            cam_rst_n,
    output logic            pix_valid,
    output cam_pkg::pixel_t pix_data,
    output logic            cam_frame_start
);

    localparam int RST_W = $clog2(`SENSOR_RST_CYCLES);
    localparam logic [RST_W-1:0] RST_LAST = RST_W'(`SENSOR_RST_CYCLES - 1);

    logic [RST_W-1:0] rst_cnt;
    logic             byte_phase;   // 1 while waiting for the low byte
    logic [7:0]       hi_byte;
    logic             vsync_q;
    logic             take_byte;

    assign take_byte = cam_rst_n & cam_href;  // camera ignored until release

    // ====================
    // sensor power-up delay
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rst_cnt   <= '0;
            cam_rst_n <= 1'b0;
        end
        else if (!cam_rst_n)
        begin
            if (rst_cnt == RST_LAST)
                cam_rst_n <= 1'b1;          // stays high from here on
            else
                rst_cnt <= rst_cnt + 1'b1;
        end
    end

    // ====================
    // byte pairing and vsync edge
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            byte_phase      <= 1'b0;
            pix_valid       <= 1'b0;
            vsync_q         <= 1'b0;
            cam_frame_start <= 1'b0;
        end
        else
        begin
            vsync_q         <= cam_vsync;
            cam_frame_start <= cam_rst_n & cam_vsync & ~vsync_q;  // rising edge
            pix_valid       <= take_byte & byte_phase;  // second byte done
            if (take_byte)
                byte_phase <= ~byte_phase;
            else
                byte_phase <= 1'b0;                 // realign on every href
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_byte)
        begin
            if (!byte_phase)
                hi_byte <= cam_data;                // first byte is the high one
            else
                pix_data <= {hi_byte, cam_data};
        end
    end

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
`default_nettype none

`include "cam_settings.svh"

module sync_fifo #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     din,
    input  logic pop,
    input  logic flush,
    output T     dout,
    output logic full,
    output logic empty
);

    localparam int AW = $clog2(`FIFO_DEPTH);
    localparam logic [AW:0] CNT_MAX = (AW + 1)'(`FIFO_DEPTH);

    T              mem [`FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push_ok;
    logic          pop_ok;

    assign full    = (count == CNT_MAX);
    assign empty   = (count == '0);
    assign push_ok = push & ~full;    // push into a full FIFO is lost
    assign pop_ok  = pop & ~empty;
    assign dout    = mem[rd_ptr];     // first-word fall-through

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= din;
    end

endmodule

`default_nettype wire

/* design/cam_pkg.sv */
`default_nettype none

`include "cam_settings.svh"

package cam_pkg;

    // one RGB565 pixel, r[15:11] g[10:5] b[4:0]
    typedef logic [15:0] pixel_t;

    typedef logic [$clog2(`FRAME_PIXELS)-1:0] addr_t;  // frame RAM address

    typedef logic [7:0] rgb_t;  // one 8-bit colour channel

    // queued camera write
    typedef struct packed {
        addr_t  addr;
        pixel_t pixel;
    } wr_entry_t;

    // RAM port owner in a given cycle
    typedef enum logic {
        PORT_WR = 1'b0,
        PORT_RD = 1'b1
    } port_sel_t;

endpackage

`default_nettype wire

/* design/cam_settings.svh */
`ifndef CAM_SETTINGS_SVH
`define CAM_SETTINGS_SVH

// ====================
// display geometry
// ====================
`define H_ACTIVE 8             // active pixels per line
`define V_ACTIVE 4             // active lines per frame

`define H_FP 2                 // pixel ticks
`define H_SYNC 2
`define H_BP 4

`define V_FP 1                 // lines
`define V_SYNC 1
`define V_BP 2

`define FRAME_PIXELS (`H_ACTIVE * `V_ACTIVE)  // frame RAM depth

// ====================
// misc
// ====================
`define SENSOR_RST_CYCLES 40   // clk cycles until sensor leaves reset
`define FIFO_DEPTH 8           // entries per FIFO

`endif
